//--- Bender.yml
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/control_unit.sv
  - rtl/alu.sv
  - rtl/register_file.sv
  - rtl/hi_lo_unit.sv
  - rtl/mips_core.sv
  - target: simulation
    files:
      - verif/tb_mips_core.sv

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  alu_op_e         alu_op,
	output logic [XLEN-1:0] result,
	output logic            zero
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;
	logic            lt_signed;
	logic            lt_unsigned;

	assign sum         = a + b;	// No overflow trap
	assign diff        = a - b;
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (alu_op)
			alu_add:  result = sum;
			alu_sub:  result = diff;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_slt:  result = {{(XLEN-1){1'b0}}, lt_signed};
			alu_sltu: result = {{(XLEN-1){1'b0}}, lt_unsigned};
			alu_lui:  result = {b[15:0], 16'h0000};	// Immediate to upper half
			default:  result = sum;
		endcase
	end

	assign zero = (result == '0);	// Branch compare uses sub

endmodule

//--- rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit import mips_pkg::*; (
	input  logic [XLEN-1:0] instruction,
	output logic            reg_write,
	output logic            mem_to_reg,
	output logic            mem_write,
	output logic            alu_src_imm,
	output logic            zero_extend,
	output logic            reg_dst_rd,
	output logic            branch,
	output logic            branch_ne,
	output logic            hilo_read,
	output logic            hilo_select_hi,
	output alu_op_e         alu_op,
	output hilo_op_e        hilo_op,
	output logic            illegal
);

	opcode_e opcode;
	funct_e  funct;

	assign opcode = opcode_e'(instruction[31:26]);	// Unknown codes fall to default
	assign funct  = funct_e'(instruction[5:0]);

	always_comb begin
		reg_write      = 1'b0;	// Safe no-op defaults
		mem_to_reg     = 1'b0;
		mem_write      = 1'b0;
		alu_src_imm    = 1'b0;
		zero_extend    = 1'b0;
		reg_dst_rd     = 1'b0;
		branch         = 1'b0;
		branch_ne      = 1'b0;
		hilo_read      = 1'b0;
		hilo_select_hi = 1'b0;
		alu_op         = alu_add;
		hilo_op        = hilo_none;
		illegal        = 1'b0;
		case (opcode)
			op_r_type: begin
				reg_write  = 1'b1;	// Most R-types write rd
				reg_dst_rd = 1'b1;
				case (funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_slt:  alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_mfhi: begin
						hilo_read      = 1'b1;
						hilo_select_hi = 1'b1;
					end
					fn_mflo: hilo_read = 1'b1;
					// HI/LO writers leave the register file alone
					fn_mult: begin
						reg_write = 1'b0;
						hilo_op   = hilo_mult;
					end
					fn_multu: begin
						reg_write = 1'b0;
						hilo_op   = hilo_multu;
					end
					fn_div: begin
						reg_write = 1'b0;
						hilo_op   = hilo_div;
					end
					fn_divu: begin
						reg_write = 1'b0;
						hilo_op   = hilo_divu;
					end
					default: begin
						reg_write = 1'b0;	// Unknown funct
						illegal   = 1'b1;
					end
				endcase
			end
			op_addiu: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
			end
			op_slti: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = alu_slt;
			end
			op_andi, op_ori, op_xori, op_lui: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				zero_extend = 1'b1;	// Logic immediates are unsigned
				alu_op      = (opcode == op_andi) ? alu_and :
				              (opcode == op_ori)  ? alu_or  :
				              (opcode == op_xori) ? alu_xor : alu_lui;
			end
			op_lw: begin
				reg_write   = 1'b1;
				mem_to_reg  = 1'b1;
				alu_src_imm = 1'b1;	// Base plus offset
			end
			op_sw: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
			end
			op_beq, op_bne: begin
				branch    = 1'b1;
				branch_ne = (opcode == op_bne);
				alu_op    = alu_sub;	// Compare through zero flag
			end
			default: illegal = 1'b1;	// Unknown opcode
		endcase
	end

	// Illegal decode must be a true no-op
	a_illegal_no_write: assert final (!illegal || !(reg_write || mem_write || branch
		|| hilo_op != hilo_none));
	a_single_writer: assert final (!(reg_write && mem_write));

endmodule

//--- rtl/hi_lo_unit.sv
`timescale 1ns/1ps

module hi_lo_unit import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [XLEN-1:0] rs_data,
	input  logic [XLEN-1:0] rt_data,
	input  hilo_op_e        hilo_op,
	output logic [XLEN-1:0] hi,
	output logic [XLEN-1:0] lo
);

	logic [2*XLEN-1:0] prod_s;
	logic [2*XLEN-1:0] prod_u;
	logic [XLEN-1:0]   divisor;
	logic              div_zero;
	logic [XLEN-1:0]   quot_s, rem_s;
	logic [XLEN-1:0]   quot_u, rem_u;

	assign prod_s   = $signed(rs_data) * $signed(rt_data);	// Sign-extended to 64 bits
	assign prod_u   = rs_data * rt_data;
	assign div_zero = (rt_data == '0);
	assign divisor  = div_zero ? XLEN'(1) : rt_data;	// Keeps quotient defined

	assign quot_s = $signed(rs_data) / $signed(divisor);
	assign rem_s  = $signed(rs_data) % $signed(divisor);	// Sign follows dividend
	assign quot_u = rs_data / divisor;
	assign rem_u  = rs_data % divisor;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else begin
			case (hilo_op)
				hilo_mult:  {hi, lo} <= prod_s;
				hilo_multu: {hi, lo} <= prod_u;
				hilo_div: begin
					if (!div_zero) begin	// Divide by zero holds state
						hi <= rem_s;
						lo <= quot_s;
					end
				end
				hilo_divu: begin
					if (!div_zero) begin
						hi <= rem_u;
						lo <= quot_u;
					end
				end
				default: ;	// hilo_none holds
			endcase
		end
	end

	a_hilo_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({hi, lo}));

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [XLEN-1:0] instruction,
	input  logic            instr_valid,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] mem_addr,
	output logic [XLEN-1:0] mem_wdata,
	output logic            mem_write,
	input  logic [XLEN-1:0] mem_rdata,
	output logic            illegal_instr
);

	logic                  ctrl_reg_write, ctrl_mem_write;
	logic                  mem_to_reg, alu_src_imm, zero_extend, reg_dst_rd;
	logic                  branch, branch_ne, hilo_read, hilo_select_hi, illegal;
	alu_op_e               alu_op;
	hilo_op_e              hilo_op;
	logic [REG_ADDR_W-1:0] rs, rt, rd, w_addr;
	logic [15:0]           imm;
	logic [XLEN-1:0]       imm_ext, rs_data, rt_data, alu_b, alu_result, w_data;
	logic [XLEN-1:0]       hi, lo, pc_plus4, branch_target;
	logic                  alu_zero, branch_taken;

	assign rs  = instruction[25:21];
	assign rt  = instruction[20:16];
	assign rd  = instruction[15:11];
	assign imm = instruction[15:0];

	control_unit u_control_unit (
		.instruction    (instruction),
		.reg_write      (ctrl_reg_write),
		.mem_to_reg     (mem_to_reg),
		.mem_write      (ctrl_mem_write),
		.alu_src_imm    (alu_src_imm),
		.zero_extend    (zero_extend),
		.reg_dst_rd     (reg_dst_rd),
		.branch         (branch),
		.branch_ne      (branch_ne),
		.hilo_read      (hilo_read),
		.hilo_select_hi (hilo_select_hi),
		.alu_op         (alu_op),
		.hilo_op        (hilo_op),
		.illegal        (illegal)
	);

	assign imm_ext = zero_extend ? {16'h0000, imm} : {{16{imm[15]}}, imm};
	assign alu_b   = alu_src_imm ? imm_ext : rt_data;	// Second operand mux
	assign w_addr  = reg_dst_rd ? rd : rt;

	// Writeback select: HI/LO, load data or ALU
	assign w_data = hilo_read ? (hilo_select_hi ? hi : lo) :
	                mem_to_reg ? mem_rdata : alu_result;

	register_file u_register_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (rs),
		.rt_addr (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.w_addr  (w_addr),
		.w_data  (w_data),
		.w_en    (ctrl_reg_write && instr_valid)
	);

	alu u_alu (
		.a      (rs_data),
		.b      (alu_b),
		.alu_op (alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	hi_lo_unit u_hi_lo_unit (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.hilo_op (instr_valid ? hilo_op : hilo_none),	// Idle cycles hold HI/LO
		.hi      (hi),
		.lo      (lo)
	);

	assign mem_addr      = alu_result;	// Base plus offset
	assign mem_wdata     = rt_data;
	assign mem_write     = ctrl_mem_write && instr_valid;
	assign illegal_instr = illegal && instr_valid;

	assign pc_plus4      = pc + XLEN'(4);
	assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
	assign branch_taken  = branch && (alu_zero ^ branch_ne);	// bne inverts the compare

	// No delay slot, taken branch jumps at once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (instr_valid) begin
			pc <= branch_taken ? branch_target : pc_plus4;
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

	localparam int XLEN       = 32;	// Data word width
	localparam int REG_ADDR_W = 5;	// Register index width

	// Primary opcode field, instruction[31:26]
	typedef enum logic [5:0] {
		op_r_type = 6'h00,	// Decoded further by funct
		op_beq    = 6'h04,
		op_bne    = 6'h05,
		op_addiu  = 6'h09,
		op_slti   = 6'h0a,
		op_andi   = 6'h0c,
		op_ori    = 6'h0d,
		op_xori   = 6'h0e,
		op_lui    = 6'h0f,
		op_lw     = 6'h23,
		op_sw     = 6'h2b
	} opcode_e;

	// R-type function field, instruction[5:0]
	typedef enum logic [5:0] {
		fn_mfhi  = 6'h10,
		fn_mflo  = 6'h12,
		fn_mult  = 6'h18,
		fn_multu = 6'h19,
		fn_div   = 6'h1a,
		fn_divu  = 6'h1b,
		fn_addu  = 6'h21,
		fn_subu  = 6'h23,
		fn_and   = 6'h24,
		fn_or    = 6'h25,
		fn_xor   = 6'h26,
		fn_slt   = 6'h2a,
		fn_sltu  = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_lui
	} alu_op_e;

	// Five codes, so three bits
	typedef enum logic [2:0] {
		hilo_none,
		hilo_mult,
		hilo_multu,
		hilo_div,
		hilo_divu
	} hilo_op_e;

endpackage

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file import mips_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs_addr,
	input  logic [REG_ADDR_W-1:0] rt_addr,
	output logic [XLEN-1:0]       rs_data,
	output logic [XLEN-1:0]       rt_data,
	input  logic [REG_ADDR_W-1:0] w_addr,
	input  logic [XLEN-1:0]       w_data,
	input  logic                  w_en
);

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (w_en && w_addr != '0) begin	// $zero is read-only
			regs[w_addr] <= w_data;
		end
	end

	// Combinational reads see the pre-edge value
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- sim.f
rtl/mips_pkg.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/register_file.sv
rtl/hi_lo_unit.sv
rtl/mips_core.sv
verif/tb_mips_core.sv

//--- verif/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*;;

	localparam int NUM_INSTR  = 2000;	// Valid instructions issued
	localparam int MAX_CYCLES = 3000;	// Instructions plus idle cycles, with margin

	logic            clk = 1'b0;
	logic            rst_n;
	logic [XLEN-1:0] instruction;
	logic            instr_valid;
	logic [XLEN-1:0] pc, mem_addr, mem_wdata, mem_rdata;
	logic            mem_write, illegal_instr;

	logic [XLEN-1:0] mem [64];	// Memory seen by the DUT
	logic [31:0]     lfsr_state;
	int              cycles = 0;

	// Reference model state
	logic [XLEN-1:0] model_regs [32];
	logic [XLEN-1:0] model_mem [64];
	logic [XLEN-1:0] model_hi, model_lo, model_pc;

	mips_core #(.RESET_PC('0)) u_mips_core (
		.clk           (clk),
		.rst_n         (rst_n),
		.instruction   (instruction),
		.instr_valid   (instr_valid),
		.pc            (pc),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_write     (mem_write),
		.mem_rdata     (mem_rdata),
		.illegal_instr (illegal_instr)
	);

	always #10 clk = ~clk;	// 20 ns period

	assign mem_rdata = mem[mem_addr[7:2]];	// Combinational read, word index

	always @(posedge clk) begin
		if (mem_write) begin
			mem[mem_addr[7:2]] <= mem_wdata;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Simulation timed out after %0d cycles without finishing", cycles);
			$display("test failed");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input logic [XLEN-1:0] expected,
		input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};	// One step per bit
		end
		return v;
	endfunction

	function automatic logic [4:0] src_reg();
		logic [4:0] r;
		r = 5'(rand_bits(3));
		return (r == 5'd0) ? 5'd1 : r;	// Sources in 1..7
	endfunction

	function automatic logic known_opcode(input logic [5:0] op);
		case (op)
			op_r_type, op_beq, op_bne, op_addiu, op_slti, op_andi, op_ori, op_xori,
			op_lui, op_lw, op_sw: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic known_funct(input logic [5:0] fn);
		case (fn)
			fn_mfhi, fn_mflo, fn_mult, fn_multu, fn_div, fn_divu, fn_addu, fn_subu,
			fn_and, fn_or, fn_xor, fn_slt, fn_sltu: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] random_instr();
		logic [4:0]  cls, rs, rt, dst;
		logic [15:0] imm;
		logic [5:0]  code;
		cls  = 5'(rand_bits(5));
		rs   = src_reg();
		rt   = src_reg();
		dst  = 5'(rand_bits(3));	// $zero can be a target
		imm  = 16'(rand_bits(16));
		case (cls)
			5'd0:  code = fn_addu;
			5'd1:  code = fn_subu;
			5'd2:  code = fn_and;
			5'd3:  code = fn_or;
			5'd4:  code = fn_xor;
			5'd5:  code = fn_slt;
			5'd6:  code = fn_sltu;
			5'd7:  code = fn_mult;
			5'd8:  code = fn_multu;
			5'd9:  code = fn_div;
			5'd10: code = fn_divu;
			5'd11: code = fn_mfhi;
			5'd12: code = fn_mflo;
			5'd13: code = op_addiu;
			5'd14: code = op_slti;
			5'd15: code = op_andi;
			5'd16: code = op_ori;
			5'd17: code = op_xori;
			5'd18: code = op_lui;
			5'd21: code = op_beq;
			5'd22: code = op_bne;
			default: code = 6'(rand_bits(6));	// Only used by the illegal class
		endcase
		if (cls < 5'd13) begin
			return {6'h00, rs, rt, dst, 5'd0, code};
		end else if (cls < 5'd19) begin
			return {code, rs, dst, imm};
		end else if (cls == 5'd19) begin
			return {op_lw, 5'd0, dst, 8'h00, imm[5:0], 2'b00};	// Low 256 bytes
		end else if (cls == 5'd21 || cls == 5'd22) begin
			return {code, rs, rt, {12{imm[3]}}, imm[3:0]};	// Short branch offset
		end else if (cls == 5'd23) begin
			if (imm[15]) begin
				code = known_funct(code) ? 6'h3f : code;
				return {6'h00, rs, rt, dst, 5'd0, code};	// Unknown funct
			end
			code = known_opcode(code) ? 6'h3f : code;
			return {code, rs, rt, imm};	// Unknown opcode
		end
		return {op_sw, 5'd0, rt, 8'h00, imm[5:0], 2'b00};	// Stores fill the rest
	endfunction

	// Signed divide on magnitudes, remainder takes dividend sign
	function automatic logic [63:0] signed_divmod(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] ma, mb, q, r;
		ma = a[31] ? -a : a;
		mb = b[31] ? -b : b;
		q  = ma / mb;
		r  = ma % mb;
		q  = (a[31] ^ b[31]) ? -q : q;
		r  = a[31] ? -r : r;
		return {r, q};
	endfunction

	task automatic step_model(input logic [XLEN-1:0] word);
		logic [5:0]      op, fn;
		logic [4:0]      rs, rt, rd, w_addr;
		logic [XLEN-1:0] a, b, sext, zext, addr, w_val, next_pc;
		logic            w_en, is_store, is_illegal;
		op         = word[31:26];
		rs         = word[25:21];
		rt         = word[20:16];
		rd         = word[15:11];
		fn         = word[5:0];
		a          = model_regs[rs];
		b          = model_regs[rt];
		sext       = {{16{word[15]}}, word[15:0]};
		zext       = {16'h0000, word[15:0]};
		addr       = a + sext;
		w_en       = 1'b1;
		w_addr     = rt;	// I-type target
		w_val      = '0;
		is_store   = 1'b0;
		is_illegal = 1'b0;
		next_pc    = model_pc + 32'd4;
		case (op)
			op_r_type: begin
				w_addr = rd;
				case (fn)
					fn_addu: w_val = a + b;
					fn_subu: w_val = a - b;
					fn_and:  w_val = a & b;
					fn_or:   w_val = a | b;
					fn_xor:  w_val = a ^ b;
					fn_slt:  w_val = {31'b0, $signed(a) < $signed(b)};
					fn_sltu: w_val = {31'b0, a < b};
					fn_mfhi: w_val = model_hi;
					fn_mflo: w_val = model_lo;
					fn_mult: begin
						w_en = 1'b0;
						{model_hi, model_lo} = {{32{a[31]}}, a} * {{32{b[31]}}, b};
					end
					fn_multu: begin
						w_en = 1'b0;
						{model_hi, model_lo} = {32'h0, a} * {32'h0, b};
					end
					fn_div: begin
						w_en = 1'b0;
						if (b != '0) {model_hi, model_lo} = signed_divmod(a, b);
					end
					fn_divu: begin
						w_en = 1'b0;
						if (b != '0) {model_hi, model_lo} = {a % b, a / b};
					end
					default: begin
						w_en       = 1'b0;
						is_illegal = 1'b1;
					end
				endcase
			end
			op_addiu: w_val = a + sext;
			op_slti:  w_val = {31'b0, $signed(a) < $signed(sext)};
			op_andi:  w_val = a & zext;
			op_ori:   w_val = a | zext;
			op_xori:  w_val = a ^ zext;
			op_lui:   w_val = {word[15:0], 16'h0000};
			op_lw:    w_val = model_mem[addr[7:2]];
			op_sw: begin
				w_en     = 1'b0;
				is_store = 1'b1;
			end
			op_beq, op_bne: begin
				w_en = 1'b0;
				if ((a == b) != (op == op_bne)) next_pc = model_pc + 32'd4 + {sext[29:0], 2'b00};
			end
			default: begin
				w_en       = 1'b0;
				is_illegal = 1'b1;
			end
		endcase
		check_value("pc", model_pc, pc);
		check_value("mem_write", is_store, mem_write);
		check_value("illegal_instr", is_illegal, illegal_instr);
		if (is_store) begin
			check_value("sw address", addr, mem_addr);
			check_value("sw data", b, mem_wdata);	// Register state seen through the bus
			model_mem[addr[7:2]] = b;
		end
		if (w_en && w_addr != 5'd0) model_regs[w_addr] = w_val;	// $zero stays zero
		model_pc = next_pc;
	endtask

	initial begin
		int              issued;
		logic [XLEN-1:0] word;
		logic            valid;
		issued      = 0;
		lfsr_state  = 32'h903a;
		rst_n       = 1'b0;
		instruction = '0;
		instr_valid = 1'b0;
		model_pc    = '0;
		model_hi    = '0;
		model_lo    = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			mem[i]       = 32'h1234_5678 ^ (i * 32'h9e37_79b9);	// Every word differs
			model_mem[i] = 32'h1234_5678 ^ (i * 32'h9e37_79b9);
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("reset pc", '0, pc);
		check_value("reset mem_write", '0, mem_write);
		check_value("reset illegal_instr", '0, illegal_instr);
		while (issued < NUM_INSTR) begin
			valid = (rand_bits(4) < 13);	// About 80 percent busy
			word  = valid ? random_instr() : rand_bits(32);
			@(posedge clk);
			instruction <= word;
			instr_valid <= valid;
			@(negedge clk);	// Outputs settled
			if (valid) begin
				step_model(word);
				issued++;
			end else begin
				check_value("idle pc hold", model_pc, pc);
				check_value("idle mem_write", '0, mem_write);
				check_value("idle illegal_instr", '0, illegal_instr);
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		@(negedge clk);
		check_value("final pc", model_pc, pc);
		$display("test passed");
		$finish;
	end

endmodule
